/* rtl/conv_pkg.sv */
package conv_pkg;

    // image and window geometry
    localparam int IMG_ROWS    = 10;
    localparam int IMG_COLS    = 12;
    localparam int WIN_SIZE    = 3;
    localparam int KERNEL_TAPS = WIN_SIZE * WIN_SIZE;

    // valid window positions
    localparam int OUT_ROWS    = IMG_ROWS - WIN_SIZE + 1;
    localparam int OUT_COLS    = IMG_COLS - WIN_SIZE + 1;
    localparam int NUM_RESULTS = OUT_ROWS * OUT_COLS;

    localparam int PIXEL_WIDTH       = 4;
    localparam int RESULT_ADDR_WIDTH = 7;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // row * OUT_COLS + col
    typedef logic [RESULT_ADDR_WIDTH-1:0] result_addr_t;

    // taps in row-major order, tap 0 at top left
    typedef struct packed {
        pixel_t [KERNEL_TAPS-1:0] taps;
        result_addr_t             addr;
        logic                     last;
    } window_t;

    // fixed source image, one line per row
    localparam pixel_t IMAGE [IMG_ROWS*IMG_COLS] = '{
        4'd3, 4'd7, 4'd2, 4'd9, 4'd0, 4'd5, 4'd1, 4'd8, 4'd4, 4'd6, 4'd3, 4'd2,
        4'd8, 4'd1, 4'd6, 4'd4, 4'd7, 4'd3, 4'd9, 4'd0, 4'd5, 4'd2, 4'd8, 4'd1,
        4'd4, 4'd9, 4'd0, 4'd2, 4'd6, 4'd8, 4'd3, 4'd5, 4'd7, 4'd1, 4'd4, 4'd9,
        4'd7, 4'd3, 4'd8, 4'd5, 4'd1, 4'd4, 4'd9, 4'd2, 4'd0, 4'd6, 4'd7, 4'd3,
        4'd2, 4'd6, 4'd4, 4'd0, 4'd8, 4'd7, 4'd5, 4'd3, 4'd1, 4'd9, 4'd2, 4'd4,
        4'd9, 4'd0, 4'd7, 4'd3, 4'd5, 4'd2, 4'd8, 4'd6, 4'd4, 4'd1, 4'd9, 4'd0,
        4'd5, 4'd8, 4'd1, 4'd6, 4'd4, 4'd9, 4'd2, 4'd7, 4'd3, 4'd0, 4'd5, 4'd8,
        4'd1, 4'd4, 4'd9, 4'd2, 4'd7, 4'd0, 4'd6, 4'd8, 4'd5, 4'd3, 4'd1, 4'd4,
        4'd6, 4'd2, 4'd5, 4'd8, 4'd3, 4'd1, 4'd7, 4'd4, 4'd9, 4'd0, 4'd6, 4'd2,
        4'd0, 4'd7, 4'd3, 4'd9, 4'd5, 4'd6, 4'd4, 4'd1, 4'd8, 4'd2, 4'd0, 4'd7
    };

endpackage

/* rtl/window_fetch.sv */
module window_fetch (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              en,
    output logic              busy,
    output logic              start,
    output logic              win_valid,
    output conv_pkg::window_t win
);

    localparam int ROW_W = $clog2(conv_pkg::OUT_ROWS);
    localparam int COL_W = $clog2(conv_pkg::OUT_COLS);

    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(conv_pkg::OUT_ROWS - 1);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(conv_pkg::OUT_COLS - 1);

    // top left corner of the current window
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;

    // set when a run ends, held until en goes low
    logic finished;

    logic launch;
    logic pos_last;

    assign launch    = en && !busy && !finished;
    assign pos_last  = (row_q == ROW_LAST) && (col_q == COL_LAST);
    assign win_valid = busy;

    // gather the 3x3 neighbourhood straight from the image
    always_comb begin
        int base;
        base = int'(row_q) * conv_pkg::IMG_COLS + int'(col_q);
        for (int r = 0; r < conv_pkg::WIN_SIZE; r++) begin
            for (int c = 0; c < conv_pkg::WIN_SIZE; c++) begin
                win.taps[r * conv_pkg::WIN_SIZE + c] =
                    conv_pkg::IMAGE[base + r * conv_pkg::IMG_COLS + c];
            end
        end
        win.addr = conv_pkg::result_addr_t'(int'(row_q) * conv_pkg::OUT_COLS + int'(col_q));
        win.last = pos_last;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            start    <= 1'b0;
            finished <= 1'b0;
            row_q    <= '0;
            col_q    <= '0;
        end else begin
            start    <= launch;
            // any low cycle on en rearms the next run
            finished <= en && (finished || (busy && pos_last));

            if (launch) begin
                busy  <= 1'b1;
                row_q <= '0;
                col_q <= '0;
            end else if (busy) begin
                if (pos_last) begin
                    busy  <= 1'b0;
                    row_q <= '0;
                    col_q <= '0;
                end else if (col_q == COL_LAST) begin
                    // wrap to the start of the next row
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/conv_mac.sv */
module conv_mac #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic [conv_pkg::KERNEL_TAPS-1:0][DATA_WIDTH-1:0] kernel,
    input  logic                                              win_valid,
    input  conv_pkg::window_t                                 win,
    output logic                                              sum_valid,
    output conv_pkg::result_addr_t                            sum_addr,
    output logic                                              sum_last,
    output logic [DATA_WIDTH-1:0]                             sum
);

    logic [DATA_WIDTH-1:0] prod      [conv_pkg::KERNEL_TAPS];
    logic [DATA_WIDTH-1:0] group_sum [conv_pkg::WIN_SIZE];
    logic [DATA_WIDTH-1:0] total;

    // nine products, all kept modulo 2^DATA_WIDTH
    always_comb begin
        for (int i = 0; i < conv_pkg::KERNEL_TAPS; i++) begin
            prod[i] = kernel[i] * DATA_WIDTH'(win.taps[i]);
        end
    end

    // one group per kernel row, then across the rows
    always_comb begin
        total = '0;
        for (int g = 0; g < conv_pkg::WIN_SIZE; g++) begin
            group_sum[g] = '0;
            for (int t = 0; t < conv_pkg::WIN_SIZE; t++) begin
                group_sum[g] = group_sum[g] + prod[g * conv_pkg::WIN_SIZE + t];
            end
            total = total + group_sum[g];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= win_valid;
        end
    end

    // result travels with its window's address and last mark
    always_ff @(posedge clk) begin
        if (win_valid) begin
            sum      <= total;
            sum_addr <= win.addr;
            sum_last <= win.last;
        end
    end

endmodule

/* rtl/result_store.sv */
module result_store #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic                   sum_valid,
    input  conv_pkg::result_addr_t sum_addr,
    input  logic                   sum_last,
    input  logic [DATA_WIDTH-1:0]  sum,
    input  conv_pkg::result_addr_t rd_addr,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   done
);

    logic [DATA_WIDTH-1:0] mem [conv_pkg::NUM_RESULTS];
    logic                  done_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < conv_pkg::NUM_RESULTS; i++) begin
                mem[i] <= '0;
            end
        end else if (start) begin
            // a new run wipes the previous results
            for (int i = 0; i < conv_pkg::NUM_RESULTS; i++) begin
                mem[i] <= '0;
            end
        end else if (sum_valid) begin
            mem[sum_addr] <= sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_q <= 1'b0;
        end else if (start) begin
            done_q <= 1'b0;
        end else if (sum_valid && sum_last) begin
            done_q <= 1'b1;
        end
    end

    // old done hidden while the start strobe is up, so busy and done never overlap
    assign done = done_q && !start;

    // addresses past the last result read as zero
    always_comb begin
        if (int'(rd_addr) < conv_pkg::NUM_RESULTS) begin
            rd_data = mem[rd_addr];
        end else begin
            rd_data = '0;
        end
    end

endmodule

/* rtl/conv_top.sv */
module conv_top #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic                                              en,
    input  logic [conv_pkg::KERNEL_TAPS-1:0][DATA_WIDTH-1:0] kernel,
    input  conv_pkg::result_addr_t                            rd_addr,
    output logic [DATA_WIDTH-1:0]                             rd_data,
    output logic                                              busy,
    output logic                                              done
);

    // fetch to mac
    logic              start;
    logic              win_valid;
    conv_pkg::window_t win;

    // mac to store
    logic                   sum_valid;
    conv_pkg::result_addr_t sum_addr;
    logic                   sum_last;
    logic [DATA_WIDTH-1:0]  sum;

    window_fetch u_fetch (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .busy      (busy),
        .start     (start),
        .win_valid (win_valid),
        .win       (win)
    );

    conv_mac #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mac (
        .clk       (clk),
        .reset_n   (reset_n),
        .kernel    (kernel),
        .win_valid (win_valid),
        .win       (win),
        .sum_valid (sum_valid),
        .sum_addr  (sum_addr),
        .sum_last  (sum_last),
        .sum       (sum)
    );

    result_store #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_store (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .sum_valid (sum_valid),
        .sum_addr  (sum_addr),
        .sum_last  (sum_last),
        .sum       (sum),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .done      (done)
    );

endmodule

/* dv/conv_checker.sv */
module conv_checker (
    input logic clk,
    input logic reset_n,
    input logic busy,
    input logic done
);

    localparam logic [7:0] RUN_LEN = 8'(conv_pkg::NUM_RESULTS);

    // cycles busy has been high in this run
    logic [7:0] busy_len;
    // cycles since busy first seen high, saturates
    logic [7:0] since_start;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_len    <= '0;
            since_start <= '0;
        end else begin
            busy_len <= busy ? busy_len + 8'd1 : 8'd0;
            if (busy && busy_len == 8'd0) begin
                since_start <= 8'd1;
            end else if (since_start != 8'd0 && since_start != 8'hff) begin
                since_start <= since_start + 8'd1;
            end
        end
    end

    no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        !(busy && done))
        else $error("busy and done are high together");

    busy_bounded: assert property (@(posedge clk) disable iff (!reset_n)
        busy |-> busy_len < RUN_LEN)
        else $error("busy stayed high past one run");

    busy_length: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy) |-> busy_len == RUN_LEN)
        else $error("busy fell after %0d cycles", busy_len);

    done_delay: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(done) |-> since_start == RUN_LEN + 8'd1)
        else $error("done rose %0d cycles after busy", since_start);

endmodule

bind conv_top conv_checker u_checker (
    .clk     (clk),
    .reset_n (reset_n),
    .busy    (busy),
    .done    (done)
);

/* dv/tb_conv_top.sv */
module tb_conv_top;

    localparam int DATA_WIDTH   = 9;
    localparam int NUM_TESTS    = 3;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 20;
    localparam int MAX_IDLE     = 16;
    // seven read sweeps, three runs, the hold and two idle gaps need about 880 cycles
    localparam int MAX_CYCLES   = 1000;

    logic                                             clk;
    logic                                             reset_n;
    logic                                             en;
    logic [conv_pkg::KERNEL_TAPS-1:0][DATA_WIDTH-1:0] kernel;
    conv_pkg::result_addr_t                           rd_addr;
    logic [DATA_WIDTH-1:0]                            rd_data;
    logic                                             busy;
    logic                                             done;

    logic [conv_pkg::KERNEL_TAPS-1:0][DATA_WIDTH-1:0] gold_kernel [NUM_TESTS];
    logic [DATA_WIDTH-1:0] gold_result [NUM_TESTS][conv_pkg::NUM_RESULTS];

    integer seed;
    int     cycle_count;

    conv_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (en),
        .kernel  (kernel),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            stop_on_failure();
        end
    end

    task automatic check_result(input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] expected,
                                input string what);
        if (got !== expected) begin
            $display("Fail at time %0t: %s read %0d, expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic read_value(input int fd, output int value);
        int code;
        code = $fscanf(fd, "%d", value);
        if (code != 1) begin
            $display("The golden file ended early or holds something that is not a number");
            stop_on_failure();
        end
    endtask

    // one kernel line, then eight lines of ten results, per test
    task automatic load_golden();
        int fd;
        int value;
        fd = $fopen("dv/conv_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file dv/conv_golden.txt");
            stop_on_failure();
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < conv_pkg::KERNEL_TAPS; i++) begin
                read_value(fd, value);
                gold_kernel[t][i] = DATA_WIDTH'(value);
            end
            for (int a = 0; a < conv_pkg::NUM_RESULTS; a++) begin
                read_value(fd, value);
                gold_result[t][a] = DATA_WIDTH'(value);
            end
        end
        $fclose(fd);
    endtask

    // negative test index means the memory should still be clear
    function automatic logic [DATA_WIDTH-1:0] expected_at(input int t, input int a);
        if (t < 0) begin
            return '0;
        end
        return gold_result[t][a];
    endfunction

    task automatic check_all_results(input int t, input string label);
        @(negedge clk);
        rd_addr = '0;
        for (int a = 0; a < conv_pkg::NUM_RESULTS; a++) begin
            @(negedge clk);
            check_result(rd_data, expected_at(t, a), $sformatf("address %0d %s", a, label));
            if (a + 1 < conv_pkg::NUM_RESULTS) begin
                rd_addr = conv_pkg::result_addr_t'(a + 1);
            end
        end
    endtask

    task automatic wait_for_done();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_flag(busy, 1'b0, "busy once done is up");
    endtask

    task automatic run_test(input int t);
        @(negedge clk);
        en     = 1'b1;
        kernel = gold_kernel[t];
        // last entry is written last, so it shows the clear at start
        rd_addr = conv_pkg::result_addr_t'(conv_pkg::NUM_RESULTS - 1);
        @(negedge clk);
        check_flag(busy, 1'b1, $sformatf("busy after start of test %0d", t));
        check_flag(done, 1'b0, $sformatf("done after start of test %0d", t));
        @(negedge clk);
        check_result(rd_data, '0, $sformatf("last address after start of test %0d", t));
        wait_for_done();
        check_all_results(t, $sformatf("in test %0d", t));
    endtask

    // results and done must survive en going low
    task automatic drop_enable(input int t);
        int gap;
        gap = 1 + int'($unsigned($random(seed)) % MAX_IDLE);
        @(negedge clk);
        en = 1'b0;
        repeat (gap) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy while en is low");
            check_flag(done, 1'b1, "done while en is low");
        end
        check_all_results(t, "while en is low");
    endtask

    task automatic hold_enable();
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy with en held high after done");
            check_flag(done, 1'b1, "done with en held high after done");
        end
    endtask

    initial begin
        seed        = 32'hccf5ef54;
        cycle_count = 0;
        reset_n     = 1'b0;
        en          = 1'b0;
        kernel      = '0;
        rd_addr     = '0;

        load_golden();

        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_all_results(-1, "after reset");

        run_test(0);

        // large coefficients, results wrap
        drop_enable(0);
        run_test(1);

        // no restart while en stays high
        hold_enable();
        check_all_results(1, "after holding en high");

        drop_enable(1);
        run_test(2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* conv_top.f */
rtl/conv_pkg.sv
rtl/window_fetch.sv
rtl/conv_mac.sv
rtl/result_store.sv
rtl/conv_top.sv
dv/conv_checker.sv
dv/tb_conv_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f conv_top.f \
    --top-module tb_conv_top \
    -Mdir obj_dir

sim_out="$(./obj_dir/Vtb_conv_top 2>&1 || true)"
echo "$sim_out"

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* dv/conv_golden.txt */
1 1 1 1 1 1 1 1 1
40 40 36 44 42 42 42 38 40 36
46 38 39 40 50 43 40 28 40 41
43 37 34 41 51 46 35 34 37 45
46 36 41 35 49 46 38 32 39 41
42 35 38 44 50 49 39 34 34 38
44 40 44 38 43 48 49 37 31 31
41 45 45 40 39 44 51 39 32 29
37 49 51 41 39 37 52 40 34 25
511 511 511 511 511 511 511 511 511
472 472 476 468 470 470 470 474 472 476
466 474 473 472 462 469 472 484 472 471
469 475 478 471 461 466 477 478 475 467
466 476 471 477 463 466 474 480 473 471
470 477 474 468 462 463 473 478 478 474
468 472 468 474 469 464 463 475 481 481
471 467 467 472 473 468 461 473 480 483
475 463 461 471 473 475 460 472 478 487
1 0 0 0 0 0 0 0 16
3 39 98 137 48 85 113 24 68 150
136 81 22 68 151 35 9 96 117 50
68 9 128 114 86 56 19 149 39 65
119 51 88 37 129 100 73 18 144 6
18 102 68 144 40 119 53 3 81 137
153 32 119 3 101 130 88 54 20 65
85 136 49 22 116 73 146 7 99 32
49 148 89 98 71 16 134 40 5 115
